// ==== rv_isa_pkg.sv ====
package rv_isa_pkg;

	// datapath widths
	localparam int XLEN       = 64;
	localparam int REG_ADDR_W = 5;
	// word width for the W forms
	localparam int HALF_W     = 32;

	// major opcodes handled by the execute stage
	typedef enum logic [6:0] {
		OP        = 7'b0110011,
		OP_IMM    = 7'b0010011,
		OP_32     = 7'b0111011,
		OP_IMM_32 = 7'b0011011,
		BRANCH    = 7'b1100011,
		JAL       = 7'b1101111,
		JALR      = 7'b1100111,
		LUI       = 7'b0110111,
		AUIPC     = 7'b0010111
	} opcode_e;

	// integer alu funct3
	typedef enum logic [2:0] {
		F3_ADD  = 3'b000,
		F3_SLL  = 3'b001,
		F3_SLT  = 3'b010,
		F3_SLTU = 3'b011,
		F3_XOR  = 3'b100,
		F3_SR   = 3'b101,
		F3_OR   = 3'b110,
		F3_AND  = 3'b111
	} funct3_alu_e;

	// branch funct3, 010 and 011 unused
	typedef enum logic [2:0] {
		F3_BEQ  = 3'b000,
		F3_BNE  = 3'b001,
		F3_BLT  = 3'b100,
		F3_BGE  = 3'b101,
		F3_BLTU = 3'b110,
		F3_BGEU = 3'b111
	} funct3_br_e;

	// multiply funct3, MULW reuses F3_MUL under OP_32
	typedef enum logic [2:0] {
		F3_MUL    = 3'b000,
		F3_MULH   = 3'b001,
		F3_MULHSU = 3'b010,
		F3_MULHU  = 3'b011
	} funct3_mul_e;

	// sub and sra
	localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;
	// M extension
	localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

endpackage

// ==== ex_types_pkg.sv ====
package ex_types_pkg;

	import rv_isa_pkg::*;

	// one instruction from the issuing stage
	typedef struct packed {
		logic                  valid;
		// raw encoding, fields decoded here
		logic [31:0]           inst;
		// source operands, immediate already in op2 for I forms
		logic [XLEN-1:0]       op1;
		logic [XLEN-1:0]       op2;
		// jump and branch target operands
		logic [XLEN-1:0]       base;
		logic [XLEN-1:0]       offset;
		logic [REG_ADDR_W-1:0] rd;
	} ex_issue_t;

	// register file write
	typedef struct packed {
		logic                  valid;
		logic [REG_ADDR_W-1:0] rd;
		logic [XLEN-1:0]       data;
	} ex_wb_t;

	// new pc toward fetch
	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] target;
	} ex_redirect_t;

	// iterative multiplier sequencing
	typedef enum logic [1:0] {
		IDLE = 2'd0,
		RUN  = 2'd1,
		DONE = 2'd2
	} mul_state_e;

endpackage

// ==== ex_alu.sv ====
module ex_alu
	import rv_isa_pkg::*;
	import ex_types_pkg::*;
(
	input  ex_issue_t issue_i,
	output ex_wb_t    alu_wb_o,
	output logic      is_mul_o
);

	opcode_e           opcode;
	funct3_alu_e       f3_alu;
	funct3_mul_e       f3_mul;
	logic [6:0]        funct7;
	logic              f7_zero;
	logic              f7_alt;
	// bits 31:26 of a 64-bit immediate shift
	logic              imm6_zero;
	logic              imm6_alt;
	// sub / sra select, inst[30]
	logic              alt;
	logic [5:0]        shamt;
	logic [4:0]        shamt_w;
	logic [XLEN-1:0]   sum;
	logic [XLEN-1:0]   diff;
	logic [XLEN-1:0]   sll;
	logic [XLEN-1:0]   srl;
	logic [XLEN-1:0]   sra;
	logic [HALF_W-1:0] sll_w;
	logic [HALF_W-1:0] srl_w;
	logic [HALF_W-1:0] sra_w;
	logic              lt;
	logic              ltu;
	logic [XLEN-1:0]   result;
	logic              legal;

	function automatic logic [XLEN-1:0] sext_w(input logic [HALF_W-1:0] v);
		return {{(XLEN - HALF_W){v[HALF_W-1]}}, v};
	endfunction

	// field split
	assign opcode    = opcode_e'(issue_i.inst[6:0]);
	assign f3_alu    = funct3_alu_e'(issue_i.inst[14:12]);
	assign f3_mul    = funct3_mul_e'(issue_i.inst[14:12]);
	assign funct7    = issue_i.inst[31:25];
	assign f7_zero   = funct7 == 7'd0;
	assign f7_alt    = funct7 == FUNCT7_ALT;
	assign imm6_zero = issue_i.inst[31:26] == 6'd0;
	assign imm6_alt  = issue_i.inst[31:26] == FUNCT7_ALT[6:1];
	assign alt       = issue_i.inst[30];

	// shift amount from op2, 6 bits full width, 5 bits for W
	assign shamt   = issue_i.op2[5:0];
	assign shamt_w = issue_i.op2[4:0];

	// shared full width results
	assign sum  = issue_i.op1 + issue_i.op2;
	assign diff = issue_i.op1 - issue_i.op2;
	assign sll  = issue_i.op1 << shamt;
	assign srl  = issue_i.op1 >> shamt;
	assign sra  = $signed(issue_i.op1) >>> shamt;
	assign lt   = $signed(issue_i.op1) < $signed(issue_i.op2);
	assign ltu  = issue_i.op1 < issue_i.op2;

	// word shifts only look at the low half of op1
	assign sll_w = issue_i.op1[HALF_W-1:0] << shamt_w;
	assign srl_w = issue_i.op1[HALF_W-1:0] >> shamt_w;
	assign sra_w = $signed(issue_i.op1[HALF_W-1:0]) >>> shamt_w;

	always_comb begin
		result = '0;
		legal  = 1'b0;
		case (opcode)
			OP, OP_IMM: begin
				case (f3_alu)
					F3_ADD: begin
						// OP_IMM has immediate bits here, never a sub
						result = (opcode == OP && alt) ? diff : sum;
						legal  = (opcode == OP_IMM) || f7_zero || f7_alt;
					end
					F3_SLL: begin
						result = sll;
						legal  = (opcode == OP) ? f7_zero : imm6_zero;
					end
					F3_SR: begin
						result = alt ? sra : srl;
						legal  = (opcode == OP) ? (f7_zero || f7_alt) : (imm6_zero || imm6_alt);
					end
					F3_SLT: begin
						result = {{(XLEN - 1){1'b0}}, lt};
						legal  = (opcode == OP_IMM) || f7_zero;
					end
					F3_SLTU: begin
						result = {{(XLEN - 1){1'b0}}, ltu};
						legal  = (opcode == OP_IMM) || f7_zero;
					end
					F3_XOR: begin
						result = issue_i.op1 ^ issue_i.op2;
						legal  = (opcode == OP_IMM) || f7_zero;
					end
					F3_OR: begin
						result = issue_i.op1 | issue_i.op2;
						legal  = (opcode == OP_IMM) || f7_zero;
					end
					F3_AND: begin
						result = issue_i.op1 & issue_i.op2;
						legal  = (opcode == OP_IMM) || f7_zero;
					end
					default: legal = 1'b0;
				endcase
			end
			OP_32, OP_IMM_32: begin
				case (f3_alu)
					F3_ADD: begin
						result = sext_w((opcode == OP_32 && alt) ?
							diff[HALF_W-1:0] : sum[HALF_W-1:0]);
						legal  = (opcode == OP_IMM_32) || f7_zero || f7_alt;
					end
					F3_SLL: begin
						result = sext_w(sll_w);
						legal  = f7_zero;
					end
					F3_SR: begin
						result = sext_w(alt ? sra_w : srl_w);
						legal  = f7_zero || f7_alt;
					end
					default: legal = 1'b0;
				endcase
			end
			// link value, op1 carries pc
			JAL, JALR, AUIPC: begin
				result = sum;
				legal  = 1'b1;
			end
			LUI: begin
				result = issue_i.op1;
				legal  = 1'b1;
			end
			default: legal = 1'b0;
		endcase
	end

	assign alu_wb_o.valid = issue_i.valid && legal;
	assign alu_wb_o.rd    = issue_i.rd;
	assign alu_wb_o.data  = result;

	// multiplier takes these, the alu path stays quiet for them
	assign is_mul_o = funct7 == FUNCT7_MULDIV &&
		((opcode == OP && f3_mul inside {F3_MUL, F3_MULH, F3_MULHSU, F3_MULHU}) ||
		 (opcode == OP_32 && f3_mul == F3_MUL));

endmodule

// ==== ex_branch.sv ====
module ex_branch
	import rv_isa_pkg::*;
	import ex_types_pkg::*;
(
	input  ex_issue_t    issue_i,
	output ex_redirect_t redirect_o
);

	opcode_e    opcode;
	funct3_br_e f3_br;
	logic       eq;
	logic       lt;
	logic       ltu;
	logic       taken;

	assign opcode = opcode_e'(issue_i.inst[6:0]);
	assign f3_br  = funct3_br_e'(issue_i.inst[14:12]);

	// compares on the register operands
	assign eq  = issue_i.op1 == issue_i.op2;
	assign lt  = $signed(issue_i.op1) < $signed(issue_i.op2);
	assign ltu = issue_i.op1 < issue_i.op2;

	always_comb begin
		case (f3_br)
			F3_BEQ:  taken = eq;
			F3_BNE:  taken = !eq;
			F3_BLT:  taken = lt;
			F3_BGE:  taken = !lt;
			F3_BLTU: taken = ltu;
			F3_BGEU: taken = !ltu;
			// reserved encodings never branch
			default: taken = 1'b0;
		endcase
	end

	// jumps always redirect, branches only when taken
	assign redirect_o.valid = issue_i.valid &&
		((opcode == BRANCH && taken) || opcode == JAL || opcode == JALR);

	// target adder, shared by branch, jal and jalr
	assign redirect_o.target = issue_i.base + issue_i.offset;

endmodule

// ==== mul_fsm.sv ====
module mul_fsm
	import ex_types_pkg::*;
(
	input  logic clk,
	input  logic reset_i,
	input  logic issue_valid_i,
	input  logic is_mul_i,
	input  logic last_step_i,
	output logic accept_o,
	output logic start_mul_o,
	output logic mul_done_o,
	output logic hold_o
);

	mul_state_e state_q;
	mul_state_e state_d;

	// new work only while idle
	assign accept_o    = issue_valid_i && (state_q == IDLE);
	assign start_mul_o = accept_o && is_mul_i;
	assign mul_done_o  = state_q == DONE;
	// stall upstream until the product is registered
	assign hold_o      = state_q != IDLE;

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (start_mul_o) begin
					state_d = RUN;
				end
			end
			// one step per cycle until the counter flags the last one
			RUN: begin
				if (last_step_i) begin
					state_d = DONE;
				end
			end
			DONE:    state_d = IDLE;
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

endmodule

// ==== mul_counter.sv ====
module mul_counter
	import rv_isa_pkg::*;
#(
	parameter int RADIX_BITS = 1
) (
	input  logic clk,
	input  logic reset_i,
	input  logic start_i,
	input  logic run_i,
	output logic last_step_o
);

	localparam int STEPS = XLEN / RADIX_BITS;
	// at least one bit, also for a single step multiply
	localparam int CNT_W = (STEPS > 1) ? $clog2(STEPS) : 1;

	logic [CNT_W-1:0] count_q;

	assign last_step_o = count_q == CNT_W'(STEPS - 1);

	// parks on the last step through DONE
	always_ff @(posedge clk) begin
		if (reset_i || start_i) begin
			count_q <= '0;
		end else if (run_i && !last_step_o) begin
			count_q <= count_q + 1'b1;
		end
	end

endmodule

// ==== mul_datapath.sv ====
module mul_datapath
	import rv_isa_pkg::*;
	import ex_types_pkg::*;
#(
	parameter int RADIX_BITS = 1
) (
	input  logic                  clk,
	input  logic                  reset_i,
	input  logic                  start_i,
	input  logic                  step_i,
	input  ex_issue_t             issue_i,
	output logic [XLEN-1:0]       result_o,
	output logic [REG_ADDR_W-1:0] rd_o
);

	localparam int ACC_W = 2 * XLEN;

	opcode_e               opcode;
	funct3_mul_e           f3_mul;
	logic                  a_neg;
	logic                  b_neg;
	logic [XLEN-1:0]       a_mag;
	logic [XLEN-1:0]       b_mag;
	logic [ACC_W-1:0]      mcand_q;
	logic [XLEN-1:0]       mplier_q;
	logic [ACC_W-1:0]      acc_q;
	logic [ACC_W-1:0]      part;
	logic [ACC_W-1:0]      prod;
	logic                  neg_q;
	logic                  sel_hi_q;
	logic                  sel_w_q;
	logic [REG_ADDR_W-1:0] rd_q;

	assign opcode = opcode_e'(issue_i.inst[6:0]);
	assign f3_mul = funct3_mul_e'(issue_i.inst[14:12]);

	// signedness per funct3, MUL and MULW only need the low bits
	assign a_neg = (f3_mul == F3_MULH || f3_mul == F3_MULHSU) && issue_i.op1[XLEN-1];
	assign b_neg = (f3_mul == F3_MULH) && issue_i.op2[XLEN-1];
	// most negative value still fits as an unsigned magnitude
	assign a_mag = a_neg ? -issue_i.op1 : issue_i.op1;
	assign b_mag = b_neg ? -issue_i.op2 : issue_i.op2;

	// low multiplier digit times the shifted multiplicand
	assign part = mcand_q * {{(ACC_W - RADIX_BITS){1'b0}}, mplier_q[RADIX_BITS-1:0]};

	always_ff @(posedge clk) begin
		if (reset_i) begin
			acc_q    <= '0;
			mplier_q <= '0;
		end else if (start_i) begin
			acc_q    <= '0;
			mcand_q  <= {{XLEN{1'b0}}, a_mag};
			mplier_q <= b_mag;
			neg_q    <= a_neg ^ b_neg;
			sel_hi_q <= f3_mul != F3_MUL;
			sel_w_q  <= opcode == OP_32;
			rd_q     <= issue_i.rd;
		end else if (step_i) begin
			// multiplier is empty after the last step, extra steps add zero
			acc_q    <= acc_q + part;
			mcand_q  <= mcand_q << RADIX_BITS;
			mplier_q <= mplier_q >> RADIX_BITS;
		end
	end

	// sign fixup on the full product
	assign prod = neg_q ? -acc_q : acc_q;

	always_comb begin
		if (sel_w_q) begin
			result_o = {{(XLEN - HALF_W){prod[HALF_W-1]}}, prod[HALF_W-1:0]};
		end else if (sel_hi_q) begin
			result_o = prod[ACC_W-1:XLEN];
		end else begin
			result_o = prod[XLEN-1:0];
		end
	end

	assign rd_o = rd_q;

endmodule

// ==== ex_writeback.sv ====
module ex_writeback
	import rv_isa_pkg::*;
	import ex_types_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset_i,
	input  logic                  accept_i,
	input  logic                  is_mul_i,
	input  ex_wb_t                alu_wb_i,
	input  ex_redirect_t          redirect_i,
	input  logic                  mul_done_i,
	input  logic [XLEN-1:0]       mul_result_i,
	input  logic [REG_ADDR_W-1:0] mul_rd_i,
	output ex_wb_t                wb_o,
	output ex_redirect_t          redirect_o
);

	always_ff @(posedge clk) begin
		if (reset_i) begin
			wb_o.valid       <= 1'b0;
			redirect_o.valid <= 1'b0;
		end else begin
			// single cycle pulses unless reloaded
			wb_o.valid       <= 1'b0;
			redirect_o.valid <= 1'b0;
			if (accept_i && !is_mul_i) begin
				// alu and branch results of the accepted instruction
				wb_o       <= alu_wb_i;
				redirect_o <= redirect_i;
			end else if (mul_done_i) begin
				// accept and done never coincide, fsm is in DONE here
				wb_o.valid <= 1'b1;
				wb_o.rd    <= mul_rd_i;
				wb_o.data  <= mul_result_i;
			end
		end
	end

endmodule

// ==== ex_stage.sv ====
module ex_stage
	import rv_isa_pkg::*;
	import ex_types_pkg::*;
#(
	parameter int RADIX_BITS = 1
) (
	input  logic         clk,
	input  logic         reset_i,
	input  ex_issue_t    issue_i,
	output ex_wb_t       wb_o,
	output ex_redirect_t redirect_o,
	output logic         hold_o
);

	ex_wb_t                alu_wb;
	ex_redirect_t          br_redirect;
	logic                  is_mul;
	logic                  accept;
	logic                  start_mul;
	logic                  mul_done;
	logic                  last_step;
	logic [XLEN-1:0]       mul_result;
	logic [REG_ADDR_W-1:0] mul_rd;

	// combinational candidates from the issued instruction
	ex_alu i_alu (
		.issue_i  (issue_i),
		.alu_wb_o (alu_wb),
		.is_mul_o (is_mul)
	);

	ex_branch i_branch (
		.issue_i    (issue_i),
		.redirect_o (br_redirect)
	);

	// handshake and multiplier sequencing
	mul_fsm i_mul_fsm (
		.clk           (clk),
		.reset_i       (reset_i),
		.issue_valid_i (issue_i.valid),
		.is_mul_i      (is_mul),
		.last_step_i   (last_step),
		.accept_o      (accept),
		.start_mul_o   (start_mul),
		.mul_done_o    (mul_done),
		.hold_o        (hold_o)
	);

	// steps run while the fsm holds upstream
	mul_counter #(.RADIX_BITS(RADIX_BITS)) i_mul_counter (
		.clk         (clk),
		.reset_i     (reset_i),
		.start_i     (start_mul),
		.run_i       (hold_o),
		.last_step_o (last_step)
	);

	mul_datapath #(.RADIX_BITS(RADIX_BITS)) i_mul_datapath (
		.clk      (clk),
		.reset_i  (reset_i),
		.start_i  (start_mul),
		.step_i   (hold_o),
		.issue_i  (issue_i),
		.result_o (mul_result),
		.rd_o     (mul_rd)
	);

	// output registers
	ex_writeback i_writeback (
		.clk          (clk),
		.reset_i      (reset_i),
		.accept_i     (accept),
		.is_mul_i     (is_mul),
		.alu_wb_i     (alu_wb),
		.redirect_i   (br_redirect),
		.mul_done_i   (mul_done),
		.mul_result_i (mul_result),
		.mul_rd_i     (mul_rd),
		.wb_o         (wb_o),
		.redirect_o   (redirect_o)
	);

endmodule

// ==== tb_ex_stage.sv ====
module tb_ex_stage
	import rv_isa_pkg::*;
	import ex_types_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int RADIX_BITS = 1;

	// one table row, name kept in a parallel queue
	typedef struct packed {
		logic [31:0]           inst;
		logic [XLEN-1:0]       op1;
		logic [XLEN-1:0]       op2;
		logic [XLEN-1:0]       base;
		logic [XLEN-1:0]       offset;
		logic [REG_ADDR_W-1:0] rd;
	} entry_t;

	logic         clk = 1'b0;
	logic         reset_i;
	ex_issue_t    issue_i;
	ex_wb_t       wb_o;
	ex_redirect_t redirect_o;
	logic         hold_o;

	entry_t tests[$];
	string  names[$];
	int     errors = 0;
	int     checks = 0;
	int     cycles = 0;
	int     limit_cycles;
	integer seed = 32'hc54a;

	ex_stage #(.RADIX_BITS(RADIX_BITS)) i_dut (
		.clk        (clk),
		.reset_i    (reset_i),
		.issue_i    (issue_i),
		.wb_o       (wb_o),
		.redirect_o (redirect_o),
		.hold_o     (hold_o)
	);

	initial begin
		forever #2 clk = ~clk;
	end

	// run limit, scaled by the table once it is built
	always @(posedge clk) begin
		cycles++;
		if (cycles >= limit_cycles) begin
			$display("timeout, run stopped after %0d cycles", cycles);
			$display("checks %0d, errors %0d", checks, errors);
			$display(">>> FAIL");
			$finish;
		end
	end

	// register fields left at zero, the DUT takes operands from issue_i
	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
		input logic [6:0] opc);
		return {f7, 10'd0, f3, 5'd0, opc};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
		input logic [6:0] opc);
		return {imm, 5'd0, f3, 5'd0, opc};
	endfunction

	// RV64 integer ops on full width
	function automatic logic [XLEN-1:0] int_op(input logic [2:0] f3, input logic alt,
		input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		logic [XLEN-1:0] r;
		case (f3)
			3'd0: r = alt ? a - b : a + b;
			3'd1: r = a << b[5:0];
			3'd2: r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
			3'd3: r = (a < b) ? 64'd1 : 64'd0;
			3'd4: r = a ^ b;
			3'd5: begin
				if (alt) begin
					r = $signed(a) >>> b[5:0];
				end else begin
					r = a >> b[5:0];
				end
			end
			3'd6: r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	// W forms, 32-bit result sign extended
	function automatic logic [XLEN-1:0] word_op(input logic [2:0] f3, input logic alt,
		input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		logic [HALF_W-1:0] w;
		if (f3 == 3'd1) begin
			w = a[31:0] << b[4:0];
		end else if (f3 == 3'd5 && alt) begin
			w = $signed(a[31:0]) >>> b[4:0];
		end else if (f3 == 3'd5) begin
			w = a[31:0] >> b[4:0];
		end else begin
			w = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
		end
		return {{(XLEN - HALF_W){w[HALF_W-1]}}, w};
	endfunction

	// reference model of the execute rules
	task automatic predict(input entry_t e, output logic is_mul, output logic wb_v,
		output logic [XLEN-1:0] wb_d, output logic rd_v, output logic [XLEN-1:0] rd_t);
		logic [6:0]               opc;
		logic [2:0]               f3;
		logic [6:0]               f7;
		logic signed [2*XLEN-1:0] a_s;
		logic signed [2*XLEN-1:0] b_s;
		logic [2*XLEN-1:0]        a_u;
		logic [2*XLEN-1:0]        b_u;
		logic signed [2*XLEN-1:0] p;
		opc    = e.inst[6:0];
		f3     = e.inst[14:12];
		f7     = e.inst[31:25];
		is_mul = 1'b0;
		wb_v   = 1'b0;
		wb_d   = '0;
		rd_v   = 1'b0;
		rd_t   = e.base + e.offset;
		case (opc)
			OP: begin
				if (f7 == 7'h00 || (f7 == FUNCT7_ALT && (f3 == 3'd0 || f3 == 3'd5))) begin
					wb_v = 1'b1;
					wb_d = int_op(f3, f7 == FUNCT7_ALT, e.op1, e.op2);
				end else if (f7 == FUNCT7_MULDIV && f3 < 3'd4) begin
					is_mul = 1'b1;
				end
			end
			OP_IMM: begin
				// shift immediates carry their own funct6
				wb_v = (f3 == 3'd1) ? e.inst[31:26] == 6'd0 :
					(f3 == 3'd5) ? (e.inst[31:26] == 6'd0 || e.inst[31:26] == 6'b010000) : 1'b1;
				wb_d = int_op(f3, f3 == 3'd5 && e.inst[30], e.op1, e.op2);
			end
			OP_32: begin
				if ((f7 == 7'h00 && (f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5)) ||
					(f7 == FUNCT7_ALT && (f3 == 3'd0 || f3 == 3'd5))) begin
					wb_v = 1'b1;
					wb_d = word_op(f3, f7 == FUNCT7_ALT, e.op1, e.op2);
				end else if (f7 == FUNCT7_MULDIV && f3 == 3'd0) begin
					is_mul = 1'b1;
				end
			end
			OP_IMM_32: begin
				wb_v = f3 == 3'd0 || (f3 == 3'd1 && f7 == 7'h00) ||
					(f3 == 3'd5 && (f7 == 7'h00 || f7 == FUNCT7_ALT));
				wb_d = word_op(f3, f3 == 3'd5 && f7 == FUNCT7_ALT, e.op1, e.op2);
			end
			BRANCH: begin
				case (f3)
					3'd0: rd_v = e.op1 == e.op2;
					3'd1: rd_v = e.op1 != e.op2;
					3'd4: rd_v = $signed(e.op1) < $signed(e.op2);
					3'd5: rd_v = $signed(e.op1) >= $signed(e.op2);
					3'd6: rd_v = e.op1 < e.op2;
					3'd7: rd_v = e.op1 >= e.op2;
					default: rd_v = 1'b0;
				endcase
			end
			JAL, JALR: begin
				wb_v = 1'b1;
				wb_d = e.op1 + e.op2;
				rd_v = 1'b1;
			end
			LUI: begin
				wb_v = 1'b1;
				wb_d = e.op1;
			end
			AUIPC: begin
				wb_v = 1'b1;
				wb_d = e.op1 + e.op2;
			end
			default: wb_v = 1'b0;
		endcase
		if (is_mul) begin
			// full 128-bit product, signedness per funct3
			a_s = $signed(e.op1);
			b_s = $signed(e.op2);
			a_u = e.op1;
			b_u = e.op2;
			if (f3 == 3'd1) begin
				p = a_s * b_s;
			end else if (f3 == 3'd2) begin
				p = a_s * $signed(b_u);
			end else begin
				p = a_u * b_u;
			end
			wb_v = 1'b1;
			wb_d = (f3 == 3'd0) ? p[XLEN-1:0] : p[2*XLEN-1:XLEN];
			if (opc == OP_32) begin
				wb_d = {{(XLEN - HALF_W){p[HALF_W-1]}}, p[HALF_W-1:0]};
			end
		end
	endtask

	task automatic add_entry(input string name, input logic [31:0] inst,
		input logic [XLEN-1:0] op1, input logic [XLEN-1:0] op2,
		input logic [XLEN-1:0] base, input logic [XLEN-1:0] offset);
		entry_t e;
		e.inst   = inst;
		e.op1    = op1;
		e.op2    = op2;
		e.base   = base;
		e.offset = offset;
		// spread rd over x1..x31
		e.rd     = REG_ADDR_W'(tests.size() % 31 + 1);
		tests.push_back(e);
		names.push_back(name);
	endtask

	task automatic build_tests();
		logic [31:0]     mul_inst [5];
		string           mul_name [5];
		logic [2:0]      br_f3 [6];
		logic [XLEN-1:0] br_a [3];
		logic [XLEN-1:0] br_b [3];
		logic [XLEN-1:0] min_v;
		min_v = {1'b1, {(XLEN - 1){1'b0}}};
		add_entry("add", enc_r(7'h00, 3'd0, OP), 64'h0123_4567_89ab_cdef,
			64'h1111_1111_1111_1111, 0, 0);
		add_entry("sub", enc_r(FUNCT7_ALT, 3'd0, OP), 64'd5, 64'd9, 0, 0);
		add_entry("sll", enc_r(7'h00, 3'd1, OP), 64'h8000_0000_0000_0001, 64'd67, 0, 0);
		add_entry("srl", enc_r(7'h00, 3'd5, OP), 64'hf000_0000_0000_0000, 64'd4, 0, 0);
		add_entry("sra", enc_r(FUNCT7_ALT, 3'd5, OP), 64'hf000_0000_0000_0000, 64'd8, 0, 0);
		add_entry("slt", enc_r(7'h00, 3'd2, OP), -64'd5, 64'd3, 0, 0);
		add_entry("sltu", enc_r(7'h00, 3'd3, OP), -64'd5, 64'd3, 0, 0);
		add_entry("xor", enc_r(7'h00, 3'd4, OP), 64'hff00_ff00_ff00_ff00,
			64'h0ff0_0ff0_0ff0_0ff0, 0, 0);
		add_entry("or", enc_r(7'h00, 3'd6, OP), 64'h1234_0000_0000_0000,
			64'h0000_0000_0000_5678, 0, 0);
		add_entry("and", enc_r(7'h00, 3'd7, OP), -64'd1, 64'h0f0f_0f0f_f0f0_f0f0, 0, 0);
		add_entry("addi", enc_i(12'hfff, 3'd0, OP_IMM), 64'd10, -64'd1, 0, 0);
		add_entry("slli", enc_i(12'd12, 3'd1, OP_IMM), 64'h0000_0000_00ab_cdef, 64'd12, 0, 0);
		add_entry("srai", enc_i({6'b010000, 6'd40}, 3'd5, OP_IMM), min_v, 64'd40, 0, 0);
		add_entry("addw", enc_r(7'h00, 3'd0, OP_32), 64'h0000_0000_7fff_ffff, 64'd1, 0, 0);
		add_entry("subw", enc_r(FUNCT7_ALT, 3'd0, OP_32), 64'd0, 64'd1, 0, 0);
		add_entry("sllw", enc_r(7'h00, 3'd1, OP_32), 64'd1, 64'd31, 0, 0);
		add_entry("srlw", enc_r(7'h00, 3'd5, OP_32), 64'hffff_ffff_8000_0000, 64'd4, 0, 0);
		add_entry("sraw", enc_r(FUNCT7_ALT, 3'd5, OP_32), 64'h0000_0000_8000_0000, 64'd4, 0, 0);
		add_entry("addiw", enc_i(12'h800, 3'd0, OP_IMM_32), 64'hffff_ffff_0000_0000,
			-64'd2048, 0, 0);
		add_entry("sraiw", enc_i({7'b0100000, 5'd3}, 3'd5, OP_IMM_32),
			64'h0000_0000_f000_0000, 64'd3, 0, 0);
		add_entry("lui", enc_r(7'h00, 3'd0, LUI), 64'hffff_ffff_8765_4000, 64'd0, 0, 0);
		add_entry("auipc", enc_r(7'h00, 3'd0, AUIPC), 64'h8000_1000, 64'h0001_2000, 0, 0);
		// equal, signed less, unsigned less pairs
		br_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		br_a  = '{64'd5, -64'd1, 64'd1};
		br_b  = '{64'd5, 64'd1, -64'd1};
		foreach (br_f3[i]) begin
			foreach (br_a[j]) begin
				add_entry($sformatf("branch f3=%0d pair %0d", br_f3[i], j),
					enc_r(7'h00, br_f3[i], BRANCH), br_a[j], br_b[j], 64'h8000_0040, -64'd16 * j);
			end
		end
		add_entry("branch f3=2 reserved", enc_r(7'h00, 3'd2, BRANCH), 64'd1, 64'd1,
			64'h100, 64'h8);
		add_entry("jal", enc_r(7'h00, 3'd0, JAL), 64'h8000_0100, 64'd4, 64'h8000_0100, 64'h800);
		add_entry("jalr", enc_r(7'h00, 3'd0, JALR), 64'h8000_0200, 64'd4, 64'h1234_5670, -64'd4);
		add_entry("unknown opcode", enc_r(7'h00, 3'd0, 7'b0001011), 64'd1, 64'd2, 64'h40, 64'h0);
		add_entry("op funct7=02", enc_r(7'h02, 3'd0, OP), 64'd1, 64'd2, 0, 0);
		add_entry("op div", enc_r(FUNCT7_MULDIV, 3'd4, OP), 64'd100, 64'd7, 0, 0);
		mul_inst = '{enc_r(FUNCT7_MULDIV, 3'd0, OP), enc_r(FUNCT7_MULDIV, 3'd1, OP),
			enc_r(FUNCT7_MULDIV, 3'd2, OP), enc_r(FUNCT7_MULDIV, 3'd3, OP),
			enc_r(FUNCT7_MULDIV, 3'd0, OP_32)};
		mul_name = '{"mul", "mulh", "mulhsu", "mulhu", "mulw"};
		foreach (mul_inst[k]) begin
			add_entry({mul_name[k], " min*min"}, mul_inst[k], min_v, min_v, 0, 0);
			add_entry({mul_name[k], " ones*min"}, mul_inst[k], -64'd1, min_v, 0, 0);
			add_entry({mul_name[k], " zero*rand"}, mul_inst[k], 64'd0,
				{$random(seed), $random(seed)}, 0, 0);
			add_entry({mul_name[k], " rand*rand 0"}, mul_inst[k], {$random(seed), $random(seed)},
				{$random(seed), $random(seed)}, 0, 0);
			add_entry({mul_name[k], " rand*rand 1"}, mul_inst[k], {$random(seed), $random(seed)},
				{$random(seed), $random(seed)}, 0, 0);
		end
		// alu issue once the multiplier is idle again
		add_entry("addi after mul", enc_i(12'd7, 3'd0, OP_IMM), 64'd35, 64'd7, 0, 0);
	endtask

	task automatic check_value(input string name, input string what,
		input logic [XLEN-1:0] exp, input logic [XLEN-1:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("error %s: %s expected %h actual %h", name, what, exp, act);
		end
	endtask

	// pulse present or absent
	task automatic check_pulse(input string name, input string what, input logic exp,
		input logic act);
		checks++;
		if (exp && act !== 1'b1) begin
			errors++;
			$display("%s: expected %s high, it stayed low", name, what);
		end else if (!exp && act !== 1'b0) begin
			errors++;
			$display("%s: unexpected %s pulse", name, what);
		end
	endtask

	task automatic check_quiet(input string name);
		check_pulse(name, "writeback", 1'b0, wb_o.valid);
		check_pulse(name, "redirect", 1'b0, redirect_o.valid);
		check_pulse(name, "hold_o", 1'b0, hold_o);
	endtask

	initial begin
		entry_t          e;
		string           name;
		logic            is_mul;
		logic            wb_v;
		logic            rd_v;
		logic [XLEN-1:0] wb_d;
		logic [XLEN-1:0] rd_t;
		issue_i = '0;
		reset_i = 1'b1;
		build_tests();
		limit_cycles = tests.size() * (XLEN + 8) + 100;
		repeat (10) begin
			@(negedge clk);
			check_quiet("reset");
		end
		reset_i = 1'b0;
		@(negedge clk);
		check_quiet("after reset");
		foreach (tests[i]) begin
			e    = tests[i];
			name = names[i];
			predict(e, is_mul, wb_v, wb_d, rd_v, rd_t);
			check_pulse(name, "hold_o before issue", 1'b0, hold_o);
			issue_i.valid  = 1'b1;
			issue_i.inst   = e.inst;
			issue_i.op1    = e.op1;
			issue_i.op2    = e.op2;
			issue_i.base   = e.base;
			issue_i.offset = e.offset;
			issue_i.rd     = e.rd;
			// hold_o is low here, so the next edge accepts
			@(negedge clk);
			if (is_mul) begin
				issue_i.valid = 1'b0;
				check_pulse(name, "hold_o", 1'b1, hold_o);
				while (hold_o && !wb_o.valid) begin
					check_pulse(name, "redirect", 1'b0, redirect_o.valid);
					@(negedge clk);
				end
				if (!wb_o.valid) begin
					errors++;
					$display("%s: hold_o fell without a writeback", name);
				end else begin
					// writeback lands in the cycle hold_o drops
					check_pulse(name, "hold_o with writeback", 1'b0, hold_o);
					check_value(name, "rd", e.rd, wb_o.rd);
					check_value(name, "data", wb_d, wb_o.data);
				end
				@(negedge clk);
				check_quiet(name);
			end else begin
				check_pulse(name, "writeback", wb_v, wb_o.valid);
				if (wb_v && wb_o.valid) begin
					check_value(name, "rd", e.rd, wb_o.rd);
					check_value(name, "data", wb_d, wb_o.data);
				end
				check_pulse(name, "redirect", rd_v, redirect_o.valid);
				if (rd_v && redirect_o.valid) begin
					check_value(name, "target", rd_t, redirect_o.target);
				end
				// nothing to see, watch two more cycles
				if (!wb_v && !rd_v) begin
					issue_i.valid = 1'b0;
					repeat (2) begin
						@(negedge clk);
						check_quiet(name);
					end
				end
			end
		end
		issue_i.valid = 1'b0;
		repeat (3) begin
			@(negedge clk);
			check_quiet("drain");
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
rv_isa_pkg.sv
ex_types_pkg.sv
ex_alu.sv
ex_branch.sv
mul_fsm.sv
mul_counter.sv
mul_datapath.sv
ex_writeback.sv
ex_stage.sv
tb_ex_stage.sv

// ==== Bender.yml ====
package:
  name: ex_stage

sources:
  - rv_isa_pkg.sv
  - ex_types_pkg.sv
  - ex_alu.sv
  - ex_branch.sv
  - mul_fsm.sv
  - mul_counter.sv
  - mul_datapath.sv
  - ex_writeback.sv
  - ex_stage.sv
  - target: simulation
    files:
      - tb_ex_stage.sv
